/* verilog/hcnt_pkg.sv */
//////////////////////////////////////////////////
// Widths, register map and command opcodes
// AXI4-Lite request and response structs
//////////////////////////////////////////////////

package hcnt_pkg;

  //////////////////////////////////////////////////
  // Widths and vector types

  localparam int AddrWidth   = 4;
  localparam int DataWidth   = 32;
  localparam int StrbWidth   = DataWidth / 8;
  // Widest counter a command word can carry
  localparam int MaxCntWidth = 8;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [StrbWidth-1:0]   strb_t;
  typedef logic [MaxCntWidth-1:0] operand_t;
  typedef logic [1:0]             resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  //////////////////////////////////////////////////
  // Register map

  localparam addr_t REG_CMD    = 4'h0;
  localparam addr_t REG_COUNT  = 4'h4;
  localparam addr_t REG_STATUS = 4'h8;

  // Field positions in a command write word
  localparam int CMD_OP_LSB      = 0;
  localparam int CMD_OPERAND_LSB = 8;

  // Status word bits
  localparam int STATUS_ERR_BIT  = 0;
  localparam int STATUS_IDLE_BIT = 1;

  //////////////////////////////////////////////////
  // Commands

  typedef enum logic [1:0] {
    OP_CLR  = 2'd0,
    OP_SET  = 2'd1,
    OP_INCR = 2'd2,
    OP_DECR = 2'd3
  } op_e;

  // Operand is the new value for set, the step otherwise
  typedef struct packed {
    op_e      op;
    operand_t operand;
  } cmd_t;

  //////////////////////////////////////////////////
  // AXI4-Lite bus

  // Master driven
  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axil_req_t;

  // Slave driven
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } axil_rsp_t;

endpackage

/* verilog/hcnt_cross_count.sv */
//////////////////////////////////////////////////
// Saturating cross counter with a sum check
// Primary counts up, secondary mirrors it downwards
//////////////////////////////////////////////////

module hcnt_cross_count #(
  parameter int                  CntWidth   = 8,
  parameter logic [CntWidth-1:0] ResetValue = '0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clr_i,
  input  logic                set_i,
  input  logic                incr_en_i,
  input  logic                decr_en_i,
  input  logic [CntWidth-1:0] set_cnt_i,
  input  logic [CntWidth-1:0] step_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                err_o
);

  localparam logic [CntWidth-1:0] CntMax = '1;
  // Element 0 is the primary, element 1 the secondary
  localparam logic [1:0][CntWidth-1:0] RstVals = {CntMax - ResetValue, ResetValue};

  logic [1:0][CntWidth-1:0] cnt_d;
  logic [1:0][CntWidth-1:0] cnt_q;
  logic [CntWidth:0]        sum;

  //////////////////////////////////////////////////
  // Next state per counter

  for (genvar k = 0; k < 2; k++) begin : gen_cnt
    logic                up;
    logic                dn;
    logic [CntWidth-1:0] set_val;
    logic [CntWidth-1:0] sat_val;
    logic [CntWidth:0]   ext_val;

    // Secondary moves against the primary
    assign up      = (k == 0) ? incr_en_i : decr_en_i;
    assign dn      = (k == 0) ? decr_en_i : incr_en_i;
    assign set_val = (k == 0) ? set_cnt_i : CntMax - set_cnt_i;

    // One extra bit catches the carry or borrow
    assign ext_val = up ? {1'b0, cnt_q[k]} + {1'b0, step_i} :
                          {1'b0, cnt_q[k]} - {1'b0, step_i};

    // Clamp at all ones going up, at zero going down
    assign sat_val = !ext_val[CntWidth] ? ext_val[CntWidth-1:0] :
                     up                 ? CntMax                : '0;

    // Clear beats set, set beats a step
    assign cnt_d[k] = clr_i       ? RstVals[k] :
                      set_i       ? set_val    :
                      (up || dn)  ? sat_val    : cnt_q[k];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= RstVals;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Both halves must add up to all ones
  assign sum   = {1'b0, cnt_q[0]} + {1'b0, cnt_q[1]};
  assign err_o = sum != {1'b0, CntMax};
  assign cnt_o = cnt_q[0];

  //////////////////////////////////////////////////
  // Assertions

  // Reference model of one saturated step
  function automatic logic [CntWidth-1:0] exp_step(logic [CntWidth-1:0] cnt,
                                                   logic [CntWidth-1:0] step,
                                                   logic                inc);
    int res;
    res = inc ? int'(cnt) + int'(step) : int'(cnt) - int'(step);
    if (res > int'(CntMax)) begin
      return CntMax;
    end
    if (res < 0) begin
      return '0;
    end
    return CntWidth'(res);
  endfunction

  a_clr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clr_i |=> cnt_o == ResetValue);

  a_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    set_i && !clr_i |=> cnt_o == $past(set_cnt_i));

  // Covers increments and decrements alike
  a_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (incr_en_i ^ decr_en_i) && !clr_i && !set_i
    |=> cnt_o == $past(exp_step(cnt_o, step_i, incr_en_i)));

  // The executor never asks for both directions at once
  a_one_dir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(incr_en_i && decr_en_i));

  a_no_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !err_o);

endmodule

/* verilog/hcnt_axil_slave.sv */
//////////////////////////////////////////////////
// AXI4-Lite slave for the command, count and
// status registers, pushes commands to the FIFO
//////////////////////////////////////////////////

module hcnt_axil_slave (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  hcnt_pkg::axil_req_t axil_req_i,
  output hcnt_pkg::axil_rsp_t axil_rsp_o,
  output logic                push_o,
  output hcnt_pkg::cmd_t      push_data_o,
  input  logic                full_i,
  input  hcnt_pkg::operand_t  count_i,
  input  logic                err_sticky_i,
  input  logic                idle_i
);

  logic            wr_is_cmd;
  logic            wr_accept;
  logic            bvalid_q;
  hcnt_pkg::resp_t bresp_q;
  logic            rd_accept;
  logic            rvalid_q;
  hcnt_pkg::data_t rdata_d;
  hcnt_pkg::data_t rdata_q;
  hcnt_pkg::resp_t rresp_d;
  hcnt_pkg::resp_t rresp_q;

  //////////////////////////////////////////////////
  // Write channel

  assign wr_is_cmd = axil_req_i.awaddr == hcnt_pkg::REG_CMD;

  // Address and data taken together, held off by a full FIFO
  assign wr_accept = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q &&
                     (!wr_is_cmd || !full_i);

  assign push_o = wr_accept && wr_is_cmd;

  // Command word decode, strobes play no part
  assign push_data_o.op = hcnt_pkg::op_e'(
    axil_req_i.wdata[hcnt_pkg::CMD_OP_LSB +: $bits(hcnt_pkg::op_e)]);
  assign push_data_o.operand =
    axil_req_i.wdata[hcnt_pkg::CMD_OPERAND_LSB +: hcnt_pkg::MaxCntWidth];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // Only the command register is writable
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      bresp_q <= wr_is_cmd ? hcnt_pkg::RESP_OKAY : hcnt_pkg::RESP_SLVERR;
    end
  end

  //////////////////////////////////////////////////
  // Read channel

  assign rd_accept = axil_req_i.arvalid && !rvalid_q;

  always_comb begin
    rdata_d = '0;
    rresp_d = hcnt_pkg::RESP_OKAY;
    case (axil_req_i.araddr)
      // Write only, reads as zero
      hcnt_pkg::REG_CMD: ;
      hcnt_pkg::REG_COUNT: rdata_d = hcnt_pkg::data_t'(count_i);
      hcnt_pkg::REG_STATUS: begin
        rdata_d[hcnt_pkg::STATUS_ERR_BIT]  = err_sticky_i;
        rdata_d[hcnt_pkg::STATUS_IDLE_BIT] = idle_i;
      end
      default: rresp_d = hcnt_pkg::RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read payload captured at acceptance
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  //////////////////////////////////////////////////
  // Response bundle

  assign axil_rsp_o.awready = wr_accept;
  assign axil_rsp_o.wready  = wr_accept;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = !rvalid_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

  //////////////////////////////////////////////////
  // Assertions

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q));

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

/* verilog/hcnt_cmd_fifo.sv */
//////////////////////////////////////////////////
// First-word fall-through command FIFO
//////////////////////////////////////////////////

module hcnt_cmd_fifo #(
  parameter int FifoDepth = 4
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           push_i,
  input  hcnt_pkg::cmd_t push_data_i,
  input  logic           pop_i,
  output hcnt_pkg::cmd_t pop_data_o,
  output logic           full_o,
  output logic           empty_o
);

  localparam int PtrWidth = $clog2(FifoDepth);

  // Top bit flags a wrap of the pointer
  typedef logic [PtrWidth:0] ptr_t;

  hcnt_pkg::cmd_t mem_q [FifoDepth];
  ptr_t           wr_ptr_q;
  ptr_t           rd_ptr_q;
  logic           push_en;
  logic           pop_en;

  // Same slot, same lap means empty, other lap means full
  assign empty_o = wr_ptr_q == rd_ptr_q;
  assign full_o  = (wr_ptr_q[PtrWidth] != rd_ptr_q[PtrWidth]) &&
                   (wr_ptr_q[PtrWidth-1:0] == rd_ptr_q[PtrWidth-1:0]);

  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  //////////////////////////////////////////////////
  // Pointers

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q[PtrWidth-1:0]] <= push_data_i;
    end
  end

  // Head entry shows without a read cycle
  assign pop_data_o = mem_q[rd_ptr_q[PtrWidth-1:0]];

  // Upstream must honour the full flag
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

/* verilog/hcnt_cmd_exec.sv */
//////////////////////////////////////////////////
// Command executor for the cross counter
// Sticky error and idle flag for the status word
//////////////////////////////////////////////////

module hcnt_cmd_exec #(
  parameter int CntWidth = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output logic                pop_o,
  input  hcnt_pkg::cmd_t      pop_data_i,
  input  logic                empty_i,
  output logic                cnt_clr_o,
  output logic                cnt_set_o,
  output logic                cnt_incr_o,
  output logic                cnt_decr_o,
  output logic [CntWidth-1:0] cnt_val_o,
  input  logic [CntWidth-1:0] cnt_i,
  input  logic                cnt_err_i,
  output hcnt_pkg::operand_t  count_o,
  output logic                err_sticky_o,
  output logic                idle_o
);

  logic applied_q;
  logic err_sticky_q;

  //////////////////////////////////////////////////
  // Decode

  // One command per cycle whenever the FIFO has one
  assign pop_o = !empty_i;

  always_comb begin
    cnt_clr_o  = 1'b0;
    cnt_set_o  = 1'b0;
    cnt_incr_o = 1'b0;
    cnt_decr_o = 1'b0;
    if (pop_o) begin
      case (pop_data_i.op)
        hcnt_pkg::OP_CLR:  cnt_clr_o  = 1'b1;
        hcnt_pkg::OP_SET:  cnt_set_o  = 1'b1;
        hcnt_pkg::OP_INCR: cnt_incr_o = 1'b1;
        default:           cnt_decr_o = 1'b1;
      endcase
    end
  end

  // Low operand bits serve as set value or step
  assign cnt_val_o = pop_data_i.operand[CntWidth-1:0];

  //////////////////////////////////////////////////
  // Status

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      applied_q    <= 1'b0;
      err_sticky_q <= 1'b0;
    end else begin
      applied_q    <= pop_o;
      err_sticky_q <= err_sticky_q || cnt_err_i;
    end
  end

  // Pops are immediate, so an empty FIFO leaves nothing in flight
  assign idle_o       = empty_i;
  assign err_sticky_o = err_sticky_q;

  // Widen the count for the bus
  assign count_o = hcnt_pkg::operand_t'(cnt_i);

  // Counter stays consistent after every applied command
  a_applied_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    applied_q |-> !cnt_err_i);

endmodule

/* verilog/hcnt_top.sv */
//////////////////////////////////////////////////
// Hardened event counter with AXI4-Lite port
//////////////////////////////////////////////////

module hcnt_top #(
  parameter int                  CntWidth   = 8,
  parameter logic [CntWidth-1:0] ResetValue = '0,
  parameter int                  FifoDepth  = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  hcnt_pkg::axil_req_t axil_req_i,
  output hcnt_pkg::axil_rsp_t axil_rsp_o
);

  // Slave and FIFO
  logic                push;
  hcnt_pkg::cmd_t      push_data;
  logic                full;
  // FIFO and executor
  logic                pop;
  hcnt_pkg::cmd_t      pop_data;
  logic                empty;
  // Executor and counter
  logic                cnt_clr;
  logic                cnt_set;
  logic                cnt_incr;
  logic                cnt_decr;
  logic [CntWidth-1:0] cnt_val;
  logic [CntWidth-1:0] cnt;
  logic                cnt_err;
  // Executor back to the slave
  hcnt_pkg::operand_t  count;
  logic                err_sticky;
  logic                idle;

  hcnt_axil_slave u_axil_slave (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .push_o       (push),
    .push_data_o  (push_data),
    .full_i       (full),
    .count_i      (count),
    .err_sticky_i (err_sticky),
    .idle_i       (idle)
  );

  hcnt_cmd_fifo #(
    .FifoDepth (FifoDepth)
  ) u_cmd_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .full_o      (full),
    .empty_o     (empty)
  );

  hcnt_cmd_exec #(
    .CntWidth (CntWidth)
  ) u_cmd_exec (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pop_o        (pop),
    .pop_data_i   (pop_data),
    .empty_i      (empty),
    .cnt_clr_o    (cnt_clr),
    .cnt_set_o    (cnt_set),
    .cnt_incr_o   (cnt_incr),
    .cnt_decr_o   (cnt_decr),
    .cnt_val_o    (cnt_val),
    .cnt_i        (cnt),
    .cnt_err_i    (cnt_err),
    .count_o      (count),
    .err_sticky_o (err_sticky),
    .idle_o       (idle)
  );

  // Same value feeds set and step, the control picks its meaning
  hcnt_cross_count #(
    .CntWidth   (CntWidth),
    .ResetValue (ResetValue)
  ) u_cross_count (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .clr_i     (cnt_clr),
    .set_i     (cnt_set),
    .incr_en_i (cnt_incr),
    .decr_en_i (cnt_decr),
    .set_cnt_i (cnt_val),
    .step_i    (cnt_val),
    .cnt_o     (cnt),
    .err_o     (cnt_err)
  );

endmodule

/* bench/hcnt_clk_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////

module hcnt_clk_gen #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* bench/hcnt_tb.sv */
//////////////////////////////////////////////////
// Testbench for the hardened event counter
// Replays golden AXI4-Lite transactions and checks them
//////////////////////////////////////////////////

module hcnt_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string GoldenFile    = "bench/hcnt_golden.txt";
  localparam int    TimeoutCycles = 200;

  logic                clk;
  logic                rst_n;
  hcnt_pkg::axil_req_t axil_req;
  hcnt_pkg::axil_rsp_t axil_rsp;

  // Run bookkeeping
  int error_count;
  int test_count;
  int fail_count;
  bit aborted;

  hcnt_clk_gen #(
    .PeriodNs    (40),
    .ResetCycles (3)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  hcnt_top u_hcnt_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

  //////////////////////////////////////////////////
  // Helpers

  // A wait ran out, the rest of the golden file is skipped
  task automatic give_up(input string what);
    $display("Timeout after %0d cycles waiting for %s", TimeoutCycles, what);
    error_count++;
    aborted = 1'b1;
  endtask

  task automatic check_value(input string name, input hcnt_pkg::data_t got,
                             input hcnt_pkg::data_t exp, inout bit ok);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
      ok = 1'b0;
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    // Reset drops on a falling edge, so look at it on the rising one
    while (rst_n !== 1'b1 && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      give_up("reset release");
    end
  endtask

  //////////////////////////////////////////////////
  // Bus transactions

  // Address and data together, then the response with bready high
  task automatic bus_write(input hcnt_pkg::addr_t addr, input hcnt_pkg::data_t data,
                           output hcnt_pkg::resp_t resp);
    int cycles;
    bit done;
    resp = 2'b11;
    @(negedge clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    done   = 1'b0;
    cycles = 0;
    // Ready sampled on the edge, ahead of the register updates
    while (!done && cycles < TimeoutCycles) begin
      @(posedge clk);
      done = axil_rsp.awready && axil_rsp.wready;
      cycles++;
    end
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    if (!done) begin
      give_up("write address and data handshake");
    end else begin
      axil_req.bready = 1'b1;
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < TimeoutCycles) begin
        @(posedge clk);
        done = axil_rsp.bvalid;
        resp = axil_rsp.bresp;
        cycles++;
      end
      @(negedge clk);
      axil_req.bready = 1'b0;
      if (!done) begin
        give_up("write response");
      end
    end
  endtask

  task automatic bus_read(input hcnt_pkg::addr_t addr, output hcnt_pkg::data_t rdata,
                          output hcnt_pkg::resp_t resp);
    int cycles;
    bit done;
    rdata = '0;
    resp  = 2'b11;
    @(negedge clk);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < TimeoutCycles) begin
      @(posedge clk);
      done = axil_rsp.arready;
      cycles++;
    end
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    if (!done) begin
      give_up("read address handshake");
    end else begin
      axil_req.rready = 1'b1;
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < TimeoutCycles) begin
        @(posedge clk);
        done  = axil_rsp.rvalid;
        rdata = axil_rsp.rdata;
        resp  = axil_rsp.rresp;
        cycles++;
      end
      @(negedge clk);
      axil_req.rready = 1'b0;
      if (!done) begin
        give_up("read data");
      end
    end
  endtask

  // Poll STATUS until every queued command has reached the counter
  task automatic wait_idle();
    hcnt_pkg::data_t status;
    hcnt_pkg::resp_t resp;
    int              polls;
    bit              idle;
    idle  = 1'b0;
    polls = 0;
    while (!idle && !aborted && polls < TimeoutCycles) begin
      bus_read(hcnt_pkg::REG_STATUS, status, resp);
      idle = status[hcnt_pkg::STATUS_IDLE_BIT];
      polls++;
    end
    if (!idle && !aborted) begin
      give_up("idle status");
    end
  endtask

  //////////////////////////////////////////////////
  // Golden file replay

  // One transaction per line, comment and blank lines skipped
  task automatic run_line(input string line, input int line_no);
    logic [7:0]      kind;
    hcnt_pkg::data_t addr_word;
    hcnt_pkg::data_t data;
    hcnt_pkg::data_t exp_resp;
    hcnt_pkg::data_t rdata;
    hcnt_pkg::resp_t resp;
    hcnt_pkg::addr_t addr;
    int              fields;
    bit              ok;
    fields = $sscanf(line, "%c %h %h %h", kind, addr_word, data, exp_resp);
    if (fields == 4 && (kind == "W" || kind == "R")) begin
      addr = hcnt_pkg::addr_t'(addr_word);
      ok   = 1'b1;
      test_count++;
      if (kind == "W") begin
        bus_write(addr, data, resp);
        if (!aborted) begin
          check_value("bresp", resp, exp_resp, ok);
        end
      end else begin
        // Register reads only make sense once the FIFO has drained
        if (addr == hcnt_pkg::REG_COUNT || addr == hcnt_pkg::REG_STATUS) begin
          wait_idle();
        end
        if (!aborted) begin
          bus_read(addr, rdata, resp);
        end
        if (!aborted) begin
          check_value("rdata", rdata, data, ok);
          check_value("rresp", resp, exp_resp, ok);
        end
      end
      if (aborted) begin
        ok = 1'b0;
      end
      if (!ok) begin
        fail_count++;
      end
      $display("Line %0d %s addr 0x%0h: %s", line_no, kind, addr, ok ? "ok" : "FAILED");
    end
  endtask

  initial begin
    int    fd;
    int    code;
    int    line_no;
    string line;
    axil_req    = '0;
    error_count = 0;
    test_count  = 0;
    fail_count  = 0;
    aborted     = 1'b0;
    wait_reset();
    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", GoldenFile);
      error_count++;
    end else begin
      line_no = 0;
      while (!aborted && !$feof(fd)) begin
        code = $fgets(line, fd);
        line_no++;
        if (code > 0) begin
          run_line(line, line_no);
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, fail_count, error_count);
    if (error_count == 0 && test_count > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* bench/hcnt_golden.txt */
# Columns: kind (W write, R read), address, data, response; all hex
# W checks bresp only, R checks rdata and rresp; command data is operand<<8 | opcode
# Reset state
R 4 00000000 0
R 8 00000002 0
# Set and clear
W 0 00005a01 0
R 4 0000005a 0
W 0 00000000 0
R 4 00000000 0
# Saturating steps
W 0 0000c802 0
W 0 00006402 0
R 4 000000ff 0
W 0 00001e03 0
R 4 000000e1 0
W 0 0000ff03 0
R 4 00000000 0
# Mixed steps, clamped to 0 and 255
W 0 00000000 0
W 0 00004002 0
W 0 00005003 0
W 0 00008002 0
W 0 00009002 0
W 0 00000f03 0
R 4 000000f0 0
# Burst of six commands
W 0 00002001 0
W 0 00003002 0
W 0 00001003 0
W 0 0000f002 0
W 0 00007f03 0
W 0 00000502 0
R 4 00000085 0
# Bad addresses
W c 00001002 2
R 4 00000085 0
R c 00000000 2
# Error bit still clear
R 8 00000002 0

/* files.f */
verilog/hcnt_pkg.sv
verilog/hcnt_cross_count.sv
verilog/hcnt_axil_slave.sv
verilog/hcnt_cmd_fifo.sv
verilog/hcnt_cmd_exec.sv
verilog/hcnt_top.sv
bench/hcnt_clk_gen.sv
bench/hcnt_tb.sv

/* Bender.yml */
package:
  name: hcnt

sources:
  - files:
      - verilog/hcnt_pkg.sv
      - verilog/hcnt_cross_count.sv
      - verilog/hcnt_axil_slave.sv
      - verilog/hcnt_cmd_fifo.sv
      - verilog/hcnt_cmd_exec.sv
      - verilog/hcnt_top.sv
  - target: test
    files:
      - bench/hcnt_clk_gen.sv
      - bench/hcnt_tb.sv
